/* tests/pov_testdata.txt */
# F = flush, W theta radius z = point write, Z n = n idle cycles
# R theta col0 col1 = read, expected hex column per blade (radius tag above 16 voxel bits)
F
R 0 000000 000000
R 17 000000 000000
R 31 000000 000000
W 3 5 2
R 3 050004 000000
R 19 000000 050004
W 3 9 7
W 3 12 0
R 3 0c0085 000000
R 2 000000 000000
R 4 000000 000000
W 20 1 15
R 20 018000 000000
R 4 000000 018000
W 31 31 4
R 31 1f0010 000000
R 15 000000 1f0010
W 0 2 1
R 16 000000 020002
R 0 020002 000000
Z 3
R 3 0c0085 000000
R 19 000000 0c0085
F
R 3 000000 000000
R 20 000000 000000
R 31 000000 000000
W 3 1 1
R 3 010002 000000
W 10 7 11
W 26 4 6
R 10 070800 040040
R 26 040040 070800
Z 2
W 26 8 9
R 26 080240 070800
R 11 000000 000000
Z 2

/* files.f */
+incdir+hw
hw/pov_pkg.sv
hw/voxel_dispatch.sv
hw/column_bank.sv
hw/blade_scan.sv
hw/pov_frame_buffer.sv
tests/pov_frame_buffer_chk.sv
tests/pov_scoreboard.sv
tests/pov_frame_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module pov_frame_buffer_tb -o sim_pov \
  && ./obj_dir/sim_pov +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^SIMULATION PASSED$" sim.log && echo "run_sim: pass" && exit 0 \
  || { echo "run_sim: fail"; exit 1; }

/* tests/pov_frame_buffer_tb.sv */
`timescale 1ns/1ps
`include "pov_settings.svh"

module pov_frame_buffer_tb;

  import pov_pkg::*;

  localparam int RAND_READS = 40;

  logic                      clk_in;
  logic                      rst_in;
  logic                      flush;
  logic                      new_data;
  theta_t                    theta_write;
  radius_t                   radius;
  z_t                        z;
  theta_t                    theta_read;
  logic                      busy;
  column_t [`NUM_BLADES-1:0] columns;
  logic                      exp_valid;
  column_t [`NUM_BLADES-1:0] exp_columns;
  int                        model_errors;
  int                        file_errors;
  int                        missed_reads;
  int                        reads_checked;
  logic [7:0]                cmd_q [$];   // Command letters in file order
  int                        arg_q [$];   // Numeric arguments in file order
  column_t                   col_q [$];   // Expected columns of R commands
  int                        load_errors;
  int                        watchdog_cycles;
  logic                      loaded;
  int                        seed;
  int                        total;

  pov_frame_buffer i_pov_frame_buffer (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .flush       (flush),
    .new_data    (new_data),
    .theta_write (theta_write),
    .radius      (radius),
    .z           (z),
    .theta_read  (theta_read),
    .busy        (busy),
    .columns     (columns)
  );

  pov_scoreboard i_pov_scoreboard (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .flush         (flush),
    .new_data      (new_data),
    .theta_write   (theta_write),
    .radius        (radius),
    .z             (z),
    .theta_read    (theta_read),
    .busy          (busy),
    .columns       (columns),
    .exp_valid     (exp_valid),
    .exp_columns   (exp_columns),
    .model_errors  (model_errors),
    .file_errors   (file_errors),
    .missed_reads  (missed_reads),
    .reads_checked (reads_checked)
  );

  always #20 clk_in = ~clk_in;  // 40 ns period

  task automatic load_commands();
    int         fd;
    int         ch;
    int         rc;
    int         v;
    logic [7:0] c8;
    fd = $fopen("tests/pov_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/pov_testdata.txt");
      load_errors++;
      return;
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      c8 = ch[7:0];
      if (c8 == "#") begin
        while (ch != -1 && ch != 10) ch = $fgetc(fd);  // Skip comment line
      end else if (c8 == "F") begin
        cmd_q.push_back(c8);
      end else if (c8 == "W" || c8 == "R" || c8 == "Z") begin
        cmd_q.push_back(c8);
        for (int i = 0; i < ((c8 == "W") ? 3 : 1); i++) begin
          rc = $fscanf(fd, "%d", v);
          if (rc != 1) load_errors++;
          arg_q.push_back(v);
        end
        for (int k = 0; k < ((c8 == "R") ? `NUM_BLADES : 0); k++) begin
          rc = $fscanf(fd, "%h", v);
          if (rc != 1) load_errors++;
          col_q.push_back(column_t'(v));
        end
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
    if (load_errors != 0) $display("Data file has %0d malformed fields", load_errors);
  endtask

  task automatic wait_idle();
    while (busy) @(negedge clk_in);
  endtask

  task automatic flush_banks();
    @(negedge clk_in);
    flush = 1'b1;
    @(negedge clk_in);
    flush = 1'b0;
    wait_idle();
  endtask

  task automatic write_voxel(input int th, input int rad, input int zz);
    @(negedge clk_in);
    theta_write = theta_t'(th);
    radius      = radius_t'(rad);
    z           = z_t'(zz);
    new_data    = 1'b1;
    @(negedge clk_in);
    new_data = 1'b0;
    wait_idle();
  endtask

  task automatic read_theta(input int th);
    @(negedge clk_in);
    theta_read = theta_t'(th);
    exp_valid  = 1'b1;
    for (int k = 0; k < `NUM_BLADES; k++) exp_columns[k] = col_q.pop_front();
    @(negedge clk_in);
    exp_valid = 1'b0;
  endtask

  task automatic run_commands();
    logic [7:0] cmd;
    int         a;
    int         b;
    int         c;
    while (cmd_q.size() > 0) begin
      cmd = cmd_q.pop_front();
      if (cmd == "F") begin
        flush_banks();
      end else if (cmd == "W") begin
        a = arg_q.pop_front();
        b = arg_q.pop_front();
        c = arg_q.pop_front();
        write_voxel(a, b, c);
      end else if (cmd == "R") begin
        a = arg_q.pop_front();
        read_theta(a);
      end else begin
        a = arg_q.pop_front();
        repeat (a) @(negedge clk_in);  // Idle cycles still compared to the model
      end
    end
  endtask

  task automatic random_reads();
    for (int i = 0; i < RAND_READS; i++) begin
      @(negedge clk_in);
      theta_read = theta_t'($unsigned($random(seed)) % `ROT_RES);
    end
  endtask

  initial begin
    clk_in      = 1'b0;
    rst_in      = 1'b1;
    flush       = 1'b0;
    new_data    = 1'b0;
    theta_write = '0;
    radius      = '0;
    z           = '0;
    theta_read  = '0;
    exp_valid   = 1'b0;
    exp_columns = '0;
    seed        = 76;
    loaded      = 1'b0;
    load_errors = 0;
    load_commands();
    watchdog_cycles = (cmd_q.size() + RAND_READS) * (`ROT_RES + 4) + 200;
    loaded = 1'b1;
    repeat (8) @(negedge clk_in);
    rst_in = 1'b0;
    run_commands();
    random_reads();
    repeat (3) @(negedge clk_in);  // Let the last compare happen
    total = model_errors + file_errors + missed_reads + load_errors
          + i_pov_frame_buffer.i_pov_frame_buffer_chk.assert_fails;
    $display("Errors: model %0d, data file %0d, missed reads %0d, load %0d, assertions %0d",
             model_errors, file_errors, missed_reads, load_errors,
             i_pov_frame_buffer.i_pov_frame_buffer_chk.assert_fails);
    if (total == 0 && reads_checked > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog sized from the command count
  initial begin
    wait (loaded === 1'b1);
    repeat (watchdog_cycles) @(posedge clk_in);
    $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* tests/pov_scoreboard.sv */
`timescale 1ns/1ps
`include "pov_settings.svh"

module pov_scoreboard (
  input  logic                               clk_in,
  input  logic                               rst_in,
  input  logic                               flush,
  input  logic                               new_data,
  input  pov_pkg::theta_t                    theta_write,
  input  pov_pkg::radius_t                   radius,
  input  pov_pkg::z_t                        z,
  input  pov_pkg::theta_t                    theta_read,
  input  logic                               busy,
  input  pov_pkg::column_t [`NUM_BLADES-1:0] columns,
  input  logic                               exp_valid,    // Scripted read with known result
  input  pov_pkg::column_t [`NUM_BLADES-1:0] exp_columns,
  output int                                 model_errors,
  output int                                 file_errors,
  output int                                 missed_reads,
  output int                                 reads_checked
);

  import pov_pkg::*;

  column_t                   model [`ROT_RES];  // Reference column per angle
  logic                      model_ready = 1'b0; // RAM contents unknown before first flush
  logic                      rd_pend;            // Read taken at the last rising edge
  theta_t                    rd_theta;
  logic                      exp_pend;
  column_t [`NUM_BLADES-1:0] exp_cols_q;
  column_t                   upd;
  column_t                   want;
  int                        model_cnt = 0;
  int                        file_cnt = 0;
  int                        missed_cnt = 0;
  int                        check_cnt = 0;

  assign model_errors  = model_cnt;
  assign file_errors   = file_cnt;
  assign missed_reads  = missed_cnt;
  assign reads_checked = check_cnt;

  // Track requests the DUT takes, inputs are stable here
  always @(posedge clk_in) begin
    if (rst_in) begin
      rd_pend  <= 1'b0;
      exp_pend <= 1'b0;
    end else begin
      rd_pend    <= !busy && !flush && !new_data;  // Plain read cycle
      rd_theta   <= theta_read;
      exp_pend   <= exp_valid;
      exp_cols_q <= exp_columns;
      if (!busy && flush) begin
        for (int t = 0; t < `ROT_RES; t++) begin
          model[t] <= '0;
        end
        model_ready <= 1'b1;
      end else if (!busy && new_data) begin
        upd = model[theta_write];
        upd.voxels[z] = 1'b1;                        // Voxels accumulate
        upd.radius = radius;                         // Tag is the latest one
        model[theta_write] <= upd;
      end
    end
  end

  // Outputs are settled half a cycle after the read
  always @(negedge clk_in) begin
    if (rd_pend) begin
      for (int k = 0; k < `NUM_BLADES; k++) begin
        want = model[(int'(rd_theta) + k * SECTOR_DEPTH) % `ROT_RES];  // Blade k is k sectors on
        if (model_ready && columns[k] !== want) begin
          $display("FAILED at %0t: theta %0d blade %0d got %h, model %h",
                   $time, rd_theta, k, columns[k], want);
          model_cnt++;
        end
        if (exp_pend && columns[k] !== exp_cols_q[k]) begin
          $display("FAILED at %0t: theta %0d blade %0d got %h, data file %h",
                   $time, rd_theta, k, columns[k], exp_cols_q[k]);
          file_cnt++;
        end
      end
      if (model_ready) begin
        check_cnt++;
      end
    end else if (exp_pend) begin
      $display("Scripted read at time %0t was not taken by the DUT", $time);
      missed_cnt++;
    end
  end

endmodule

/* tests/pov_frame_buffer_chk.sv */
`timescale 1ns/1ps
`include "pov_settings.svh"

module pov_frame_buffer_chk (
  input logic                               clk_in,
  input logic                               rst_in,
  input logic                               flush,
  input logic                               new_data,
  input logic                               busy,
  input pov_pkg::column_t [`NUM_BLADES-1:0] columns
);

  import pov_pkg::*;

  int   assert_fails = 0;  // Failed assertion count
  logic flush_run;         // Flush sweep in progress
  int   flush_len;         // Busy cycles seen since the flush was taken

  always @(posedge clk_in) begin
    if (rst_in) begin
      flush_run <= 1'b0;
      flush_len <= 0;
    end else if (!busy && flush) begin
      flush_run <= 1'b1;
      flush_len <= 0;
    end else if (flush_run) begin
      if (busy) begin
        flush_len <= flush_len + 1;
      end else begin
        flush_run <= 1'b0;
      end
    end
  end

  // Idle and dark right after reset
  a_reset_state: assert property (@(posedge clk_in) rst_in |=> (!busy && columns == '0))
    else begin
      $error("busy or columns not cleared after reset");
      assert_fails++;
    end

  // No column data in the cycle after a strobe
  a_gate_strobe: assert property (@(posedge clk_in) disable iff (rst_in)
    (flush || new_data) |=> columns == '0)
    else begin
      $error("columns nonzero in the cycle after a strobe");
      assert_fails++;
    end

  a_gate_busy: assert property (@(posedge clk_in) disable iff (rst_in) busy |-> columns == '0)
    else begin
      $error("columns nonzero while busy");
      assert_fails++;
    end

  // Flush sweep takes one cycle per bank row
  a_flush_short: assert property (@(posedge clk_in) disable iff (rst_in)
    (flush_run && !busy) |-> flush_len == SECTOR_DEPTH)
    else begin
      $error("flush busy time differs from bank depth");
      assert_fails++;
    end

  a_flush_long: assert property (@(posedge clk_in) disable iff (rst_in)
    (flush_run && busy) |-> flush_len < SECTOR_DEPTH)
    else begin
      $error("flush busy longer than bank depth");
      assert_fails++;
    end

endmodule

bind pov_frame_buffer pov_frame_buffer_chk i_pov_frame_buffer_chk (
  .clk_in   (clk_in),
  .rst_in   (rst_in),
  .flush    (flush),
  .new_data (new_data),
  .busy     (busy),
  .columns  (columns)
);

/* hw/pov_frame_buffer.sv */
`timescale 1ns/1ps
`include "pov_settings.svh"

module pov_frame_buffer (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                flush,
  input  logic                                new_data,
  input  pov_pkg::theta_t                     theta_write,
  input  pov_pkg::radius_t                    radius,
  input  pov_pkg::z_t                         z,
  input  pov_pkg::theta_t                     theta_read,
  output logic                                busy,
  output pov_pkg::column_t [`NUM_BLADES-1:0]  columns
);

  import pov_pkg::*;

  sector_addr_t                bank_addr;   // Shared by all banks
  radius_t                     wr_radius;
  z_t                          wr_z;
  logic [`NUM_BLADES-1:0]      wr_req;      // One strobe per bank
  logic                        clear_req;
  logic                        rd_valid;
  blade_t                      rd_blade;
  column_t [`NUM_BLADES-1:0]   rd_column;   // Bank b holds sector b

  voxel_dispatch i_voxel_dispatch (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .flush       (flush),
    .new_data    (new_data),
    .theta_write (theta_write),
    .radius      (radius),
    .z           (z),
    .theta_read  (theta_read),
    .busy        (busy),
    .bank_addr   (bank_addr),
    .wr_radius   (wr_radius),
    .wr_z        (wr_z),
    .wr_req      (wr_req),
    .clear_req   (clear_req),
    .rd_valid    (rd_valid),
    .rd_blade    (rd_blade)
  );

  // One column bank per sector
  for (genvar b = 0; b < `NUM_BLADES; b++) begin : g_bank
    column_bank i_column_bank (
      .clk_in    (clk_in),
      .rst_in    (rst_in),
      .bank_addr (bank_addr),
      .wr_req    (wr_req[b]),
      .clear_req (clear_req),
      .wr_radius (wr_radius),
      .wr_z      (wr_z),
      .rd_column (rd_column[b])
    );
  end

  blade_scan i_blade_scan (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rd_valid  (rd_valid),
    .rd_blade  (rd_blade),
    .rd_column (rd_column),
    .columns   (columns)
  );

endmodule

/* hw/blade_scan.sv */
`timescale 1ns/1ps
`include "pov_settings.svh"

module blade_scan (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                rd_valid,   // Bank data is a real read
  input  pov_pkg::blade_t                     rd_blade,   // Sector of the read angle
  input  pov_pkg::column_t [`NUM_BLADES-1:0]  rd_column,  // Straight from the banks
  output pov_pkg::column_t [`NUM_BLADES-1:0]  columns     // Output k is blade k
);

  import pov_pkg::*;

  // Bank feeding blade k sits k sectors ahead of the read angle
  function automatic int blade_src(input blade_t base, input int k);
    int sum;
    sum = int'(base) + k;
    return sum % `NUM_BLADES;          // Wrap past the last sector
  endfunction

  // Rotation and gating stay combinational on the RAM output registers
  always_comb begin
    int src;
    for (int k = 0; k < `NUM_BLADES; k++) begin
      src = blade_src(rd_blade, k);
      if (rd_valid) begin
        columns[k] = rd_column[src];
      end else begin
        columns[k] = '0;               // Busy, strobe cycle or reset
      end
    end
  end

endmodule

/* hw/column_bank.sv */
`timescale 1ns/1ps

module column_bank (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  pov_pkg::sector_addr_t bank_addr,  // Read row, also the clear row
  input  logic                  wr_req,     // Start of a point write in this sector
  input  logic                  clear_req,  // Zero bank_addr now
  input  pov_pkg::radius_t      wr_radius,
  input  pov_pkg::z_t           wr_z,
  output pov_pkg::column_t      rd_column   // Registered read data
);

  import pov_pkg::*;

  column_t      ram [SECTOR_DEPTH];          // Unknown until the first flush
  sector_addr_t wr_addr_q;                   // Row of the write in flight
  radius_t      wr_radius_q;
  z_t           wr_z_q;
  column_t      wr_data_q;                   // Merged column ready for write-back
  logic         rmw_merge;                   // Old column sits on rd_column
  logic         rmw_write;                   // Merged column is written at next edge

  // Read-modify-write sequencing
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rmw_merge <= 1'b0;
      rmw_write <= 1'b0;
    end else begin
      rmw_merge <= wr_req;                   // RAM read issued on this edge
      rmw_write <= rmw_merge;
    end
  end

  // Write request fields, held through the sequence
  always_ff @(posedge clk_in) begin
    if (wr_req) begin
      wr_addr_q   <= bank_addr;
      wr_radius_q <= wr_radius;
      wr_z_q      <= wr_z;
    end
  end

  // OR stage, keeps old voxels and replaces the radius tag
  always_ff @(posedge clk_in) begin
    if (rmw_merge) begin
      wr_data_q.voxels <= rd_column.voxels | (voxels_t'(1) << wr_z_q);
      wr_data_q.radius <= wr_radius_q;
    end
  end

  // Simple dual-port RAM, read returns the old word on a same-row write
  always_ff @(posedge clk_in) begin
    rd_column <= ram[bank_addr];
    if (clear_req) begin
      ram[bank_addr] <= '0;                  // Flush sweep row
    end else if (rmw_write) begin
      ram[wr_addr_q] <= wr_data_q;           // Write-back two edges after wr_req
    end
  end

endmodule

/* hw/voxel_dispatch.sv */
`timescale 1ns/1ps
`include "pov_settings.svh"

module voxel_dispatch (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     flush,       // Clear all banks, wins over new_data
  input  logic                     new_data,    // Point write strobe
  input  pov_pkg::theta_t          theta_write,
  input  pov_pkg::radius_t         radius,
  input  pov_pkg::z_t              z,
  input  pov_pkg::theta_t          theta_read,
  output logic                     busy,
  output pov_pkg::sector_addr_t    bank_addr,   // Shared row address for every bank
  output pov_pkg::radius_t         wr_radius,
  output pov_pkg::z_t              wr_z,
  output logic [`NUM_BLADES-1:0]   wr_req,      // One-hot, only the target sector
  output logic                     clear_req,   // All banks zero bank_addr
  output logic                     rd_valid,    // Lines up with bank read data
  output pov_pkg::blade_t          rd_blade     // Sector of the sampled theta_read
);

  import pov_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    FLUSHING,
    WRITING
  } state_t;

  state_t       state;
  sector_addr_t flush_addr;    // Row being cleared
  logic         write_step;    // Second busy cycle of a write
  logic         idle;
  logic         accept_flush;
  logic         accept_write;
  blade_t       wr_blade;
  sector_addr_t wr_addr;
  blade_t       rd_blade_c;
  sector_addr_t rd_addr;

  // Angle split, high part picks the bank and the remainder the row
  always_comb begin
    wr_blade   = blade_t'(theta_write / SECTOR_DEPTH);
    wr_addr    = sector_addr_t'(theta_write % SECTOR_DEPTH);
    rd_blade_c = blade_t'(theta_read / SECTOR_DEPTH);
    rd_addr    = sector_addr_t'(theta_read % SECTOR_DEPTH);
  end

  always_comb begin
    idle         = (state == IDLE);
    accept_flush = idle && flush;
    accept_write = idle && new_data && !flush;  // Flush takes priority
    busy         = !idle;
    clear_req    = (state == FLUSHING);
    wr_radius    = radius;                       // Bank latches these on wr_req
    wr_z         = z;

    wr_req = '0;
    if (accept_write) begin
      wr_req[wr_blade] = 1'b1;                   // Only the owning bank reads
    end

    // Write address goes out in the accept cycle so the bank reads at the same edge
    if (state == FLUSHING) begin
      bank_addr = flush_addr;
    end else if (accept_write) begin
      bank_addr = wr_addr;
    end else begin
      bank_addr = rd_addr;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= IDLE;
      flush_addr <= '0;
      write_step <= 1'b0;
      rd_valid   <= 1'b0;
    end else begin
      rd_valid <= idle && !flush && !new_data;   // Plain read cycle only

      case (state)
        IDLE: begin
          if (accept_flush) begin
            state      <= FLUSHING;
            flush_addr <= '0;
          end else if (accept_write) begin
            state      <= WRITING;
            write_step <= 1'b0;
          end
        end

        FLUSHING: begin
          flush_addr <= flush_addr + 1'b1;       // One row of every bank per cycle
          if (flush_addr == sector_addr_t'(SECTOR_DEPTH - 1)) begin
            state <= IDLE;
          end
        end

        WRITING: begin
          // Bank ORs in the first cycle and writes back at the exit edge
          write_step <= 1'b1;
          if (write_step) begin
            state <= IDLE;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Sector of the read angle, delayed to match the RAM output register
  always_ff @(posedge clk_in) begin
    rd_blade <= rd_blade_c;
  end

endmodule

/* hw/pov_pkg.sv */
`include "pov_settings.svh"

package pov_pkg;

  localparam int SECTOR_DEPTH = `ROT_RES / `NUM_BLADES;                // Rows held by each bank
  localparam int THETA_W      = $clog2(`ROT_RES);                      // Full angle index
  localparam int BLADE_W      = (`NUM_BLADES > 1) ? $clog2(`NUM_BLADES) : 1; // Keep one bit minimum
  localparam int SADDR_W      = (SECTOR_DEPTH > 1) ? $clog2(SECTOR_DEPTH) : 1;
  localparam int RADIUS_W     = $clog2(`DISPLAY_RADIUS);               // Radius tag
  localparam int Z_W          = $clog2(`DISPLAY_HEIGHT);               // Voxel select

  typedef logic [THETA_W-1:0]         theta_t;        // Angle, blade in the high part
  typedef logic [BLADE_W-1:0]         blade_t;        // Sector, also the bank number
  typedef logic [SADDR_W-1:0]         sector_addr_t;  // Row inside one bank
  typedef logic [RADIUS_W-1:0]        radius_t;
  typedef logic [Z_W-1:0]             z_t;
  typedef logic [`DISPLAY_HEIGHT-1:0] voxels_t;       // One bit per LED in the column

  // Stored column word, radius tag above the voxel bits
  typedef struct packed {
    radius_t radius;
    voxels_t voxels;
  } column_t;

endpackage

/* hw/pov_settings.svh */
`ifndef POV_SETTINGS_SVH
`define POV_SETTINGS_SVH

// Angular steps per revolution
`define ROT_RES        32
// LED arms on the rotor, one column bank each; must divide ROT_RES
`define NUM_BLADES     2
// Radial LED positions per arm
`define DISPLAY_RADIUS 32
// Voxels stacked in one column
`define DISPLAY_HEIGHT 16

`endif
